//--- Makefile
# Verilator simulation of the colour tracker

VERILATOR ?= verilator
TOP       ?= tb_color_tracker
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: simulate clean

# build, run, then decide the result from the log
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- centroid_accum.sv
module centroid_accum
    import color_track_pkg::*;
(
    input  logic           clk_pixel,
    input  logic           sys_rst_pixel,
    input  logic           hit_i,
    input  logic [x_w-1:0] x_i,
    input  logic [y_w-1:0] y_i,
    input  logic           last_i,
    output logic           com_valid_o,
    output logic [x_w-1:0] com_x_o,
    output logic [y_w-1:0] com_y_o
);

    // running sums of the current frame
    logic [sum_x_w-1:0] sum_x;
    logic [sum_y_w-1:0] sum_y;
    logic [count_w-1:0] count;

    // frame totals including a hit on the current cycle
    logic [sum_x_w-1:0] tot_x;
    logic [sum_y_w-1:0] tot_y;
    logic [count_w-1:0] tot_count;

    // divider state, dvd turns into the quotient as it shifts
    logic                          busy;
    logic                          phase_y;
    logic [$clog2(sum_x_w+1)-1:0]  bit_cnt;
    logic [sum_x_w-1:0]            dvd;
    logic [count_w-1:0]            divisor;
    logic [count_w-1:0]            rem;
    logic [sum_y_w-1:0]            sum_y_snap;
    logic [x_w-1:0]                quot_x;

    // one restoring step
    logic [count_w:0]   rem_shift;
    logic               q_bit;
    logic [count_w-1:0] rem_next;
    logic [sum_x_w-1:0] dvd_next;

    assign tot_x     = hit_i ? sum_x + sum_x_w'(x_i) : sum_x;
    assign tot_y     = hit_i ? sum_y + sum_y_w'(y_i) : sum_y;
    assign tot_count = hit_i ? count + 1'b1 : count;

    // bring down the next dividend bit, subtract when it fits
    assign rem_shift = {rem, dvd[sum_x_w-1]};
    assign q_bit     = (rem_shift >= {1'b0, divisor});
    assign rem_next  = q_bit ? count_w'(rem_shift - {1'b0, divisor}) : count_w'(rem_shift);
    assign dvd_next  = {dvd[sum_x_w-2:0], q_bit};

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            sum_x       <= '0;
            sum_y       <= '0;
            count       <= '0;
            busy        <= 1'b0;
            phase_y     <= 1'b0;
            bit_cnt     <= '0;
            com_valid_o <= 1'b0;
        end else begin
            com_valid_o <= 1'b0;
            if (last_i) begin
                // frame closed, start over for the next one
                sum_x <= '0;
                sum_y <= '0;
                count <= '0;
                // an empty frame leaves the old centre in place
                if (tot_count != '0) begin
                    busy    <= 1'b1;
                    phase_y <= 1'b0;
                    bit_cnt <= ($clog2(sum_x_w+1))'(sum_x_w);
                end
            end else begin
                sum_x <= tot_x;
                sum_y <= tot_y;
                count <= tot_count;
                if (busy) begin
                    bit_cnt <= bit_cnt - 1'b1;
                    if (bit_cnt == 1) begin
                        if (phase_y) begin
                            busy        <= 1'b0;
                            com_valid_o <= 1'b1;
                        end else begin
                            // x done, y runs fewer steps
                            phase_y <= 1'b1;
                            bit_cnt <= ($clog2(sum_x_w+1))'(sum_y_w);
                        end
                    end
                end
            end
        end
    end

    // datapath of the divider and the held results
    always_ff @(posedge clk_pixel) begin
        if (last_i) begin
            dvd        <= tot_x;
            divisor    <= tot_count;
            rem        <= '0;
            sum_y_snap <= tot_y;
        end else if (busy) begin
            dvd <= dvd_next;
            rem <= rem_next;
            if (bit_cnt == 1) begin
                if (phase_y) begin
                    com_x_o <= quot_x;
                    com_y_o <= dvd_next[y_w-1:0];
                end else begin
                    quot_x <= dvd_next[x_w-1:0];
                    // y is left aligned so its top bit comes out first
                    dvd    <= {sum_y_snap, {(sum_x_w-sum_y_w){1'b0}}};
                    rem    <= '0;
                end
            end
        end
    end

endmodule

//--- color_track_pkg.sv
package color_track_pkg;

    // frame geometry of the down-sampled camera frame
    localparam int frame_w = 320;
    localparam int frame_h = 180;

    // raster position widths, enough for 0..319 and 0..179
    localparam int x_w = 9;
    localparam int y_w = 8;

    // buffer depth, which is also the number of credits the sender starts with
    localparam int fifo_depth = 8;
    // counts 0..fifo_depth inclusive
    localparam int credit_w = 4;

    // one expanded colour channel
    localparam int chan_w = 8;

    // channel select codes, 3 and 7 give zero
    localparam logic [2:0] sel_green = 3'd0;
    localparam logic [2:0] sel_red   = 3'd1;
    localparam logic [2:0] sel_blue  = 3'd2;
    localparam logic [2:0] sel_y     = 3'd4;
    localparam logic [2:0] sel_cr    = 3'd5;
    localparam logic [2:0] sel_cb    = 3'd6;

    // centroid accumulators, sized for a full frame of hits
    localparam int sum_x_w = 25;
    localparam int sum_y_w = 24;
    localparam int count_w = 16;

    // buffer word is {pixel, x, y, last}
    localparam int fifo_word_w   = 34;
    localparam int word_pix_lsb  = 18;
    localparam int word_x_lsb    = 9;
    localparam int word_y_lsb    = 1;
    localparam int word_last_bit = 0;

    // rgb565 pixel, seen either as the raw word or as its colour fields
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [4:0] red;
            logic [5:0] green;
            logic [4:0] blue;
        } f;
    } rgb565_u;

endpackage

//--- color_tracker_top.sv
module color_tracker_top
    import color_track_pkg::*;
(
    input  logic              clk_pixel,
    input  logic              sys_rst_pixel,
    input  logic              pix_valid_i,
    input  rgb565_u           pix_data_i,
    output logic              credit_o,
    input  logic [2:0]        chan_sel_i,
    input  logic [chan_w-1:0] lower_i,
    input  logic [chan_w-1:0] upper_i,
    input  logic              mask_ready_i,
    output logic              mask_valid_o,
    output logic              mask_o,
    output logic [chan_w-1:0] chan_o,
    output logic              com_valid_o,
    output logic [x_w-1:0]    com_x_o,
    output logic [y_w-1:0]    com_y_o
);

    // producer to buffer
    logic                   push;
    logic [fifo_word_w-1:0] push_word;

    // buffer to consumer
    logic [fifo_word_w-1:0] head_word;
    logic                   not_empty;
    logic                   pop;

    // consumer output sideband
    logic [x_w-1:0]         out_x;
    logic [y_w-1:0]         out_y;
    logic                   out_last;

    // centroid only sees pixels that actually left on the stream
    logic                   hs_hit;
    logic                   hs_last;

    assign hs_hit  = mask_valid_o && mask_ready_i && mask_o;
    assign hs_last = mask_valid_o && mask_ready_i && out_last;

    pixel_ingest u_ingest (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .pix_valid_i   (pix_valid_i),
        .pix_data_i    (pix_data_i),
        .push_o        (push),
        .word_o        (push_word)
    );

    pixel_fifo u_fifo (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .push_i        (push),
        .word_i        (push_word),
        .pop_i         (pop),
        .word_o        (head_word),
        .not_empty_o   (not_empty),
        .credit_o      (credit_o)
    );

    mask_pipeline u_mask (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .word_i        (head_word),
        .not_empty_i   (not_empty),
        .pop_o         (pop),
        .chan_sel_i    (chan_sel_i),
        .lower_i       (lower_i),
        .upper_i       (upper_i),
        .mask_ready_i  (mask_ready_i),
        .mask_valid_o  (mask_valid_o),
        .mask_o        (mask_o),
        .chan_o        (chan_o),
        .x_o           (out_x),
        .y_o           (out_y),
        .last_o        (out_last)
    );

    centroid_accum u_centroid (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .hit_i         (hs_hit),
        .x_i           (out_x),
        .y_i           (out_y),
        .last_i        (hs_last),
        .com_valid_o   (com_valid_o),
        .com_x_o       (com_x_o),
        .com_y_o       (com_y_o)
    );

endmodule

//--- mask_pipeline.sv
module mask_pipeline
    import color_track_pkg::*;
(
    input  logic                   clk_pixel,
    input  logic                   sys_rst_pixel,
    input  logic [fifo_word_w-1:0] word_i,
    input  logic                   not_empty_i,
    output logic                   pop_o,
    input  logic [2:0]             chan_sel_i,
    input  logic [chan_w-1:0]      lower_i,
    input  logic [chan_w-1:0]      upper_i,
    input  logic                   mask_ready_i,
    output logic                   mask_valid_o,
    output logic                   mask_o,
    output logic [chan_w-1:0]      chan_o,
    output logic [x_w-1:0]         x_o,
    output logic [y_w-1:0]         y_o,
    output logic                   last_o
);

    rgb565_u           pix;
    logic [chan_w-1:0] chan_val;
    logic              load;

    // saturate to one unsigned byte
    function automatic logic [chan_w-1:0] clip_byte(input int v);
        if (v < 0) begin
            return '0;
        end
        if (v > 255) begin
            return 8'd255;
        end
        return chan_w'(v);
    endfunction

    assign pix   = rgb565_u'(word_i[word_pix_lsb +: $bits(rgb565_u)]);
    // take a word whenever the output register is free or being drained
    assign load  = not_empty_i && (!mask_valid_o || mask_ready_i);
    assign pop_o = load;

    always_comb begin
        int r;
        int g;
        int b;
        r = int'({pix.f.red, 3'b000});
        g = int'({pix.f.green, 2'b00});
        b = int'({pix.f.blue, 3'b000});
        case (chan_sel_i)
            sel_green: chan_val = chan_w'(g);
            sel_red:   chan_val = chan_w'(r);
            sel_blue:  chan_val = chan_w'(b);
            sel_y:     chan_val = clip_byte(16 + ((66 * r + 129 * g + 25 * b + 128) >>> 8));
            sel_cr:    chan_val = clip_byte(128 + ((112 * r - 94 * g - 18 * b + 128) >>> 8));
            sel_cb:    chan_val = clip_byte(128 + ((-38 * r - 74 * g + 112 * b + 128) >>> 8));
            default:   chan_val = '0;
        endcase
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            mask_valid_o <= 1'b0;
        end else if (load) begin
            mask_valid_o <= 1'b1;
        end else if (mask_ready_i) begin
            mask_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (load) begin
            chan_o <= chan_val;
            mask_o <= (chan_val >= lower_i) && (chan_val <= upper_i);
            x_o    <= word_i[word_x_lsb +: x_w];
            y_o    <= word_i[word_y_lsb +: y_w];
            last_o <= word_i[word_last_bit];
        end
    end

endmodule

//--- pixel_fifo.sv
module pixel_fifo
    import color_track_pkg::*;
(
    input  logic                   clk_pixel,
    input  logic                   sys_rst_pixel,
    input  logic                   push_i,
    input  logic [fifo_word_w-1:0] word_i,
    input  logic                   pop_i,
    output logic [fifo_word_w-1:0] word_o,
    output logic                   not_empty_o,
    output logic                   credit_o
);

    // storage and circular pointers
    logic [fifo_word_w-1:0]          mem [fifo_depth];
    logic [$clog2(fifo_depth)-1:0]   wr_ptr;
    logic [$clog2(fifo_depth)-1:0]   rd_ptr;
    logic [credit_w-1:0]             count;
    logic                            wr_en;
    logic                            rd_en;

    // credits keep the sender from overrunning, full check is a backstop
    assign wr_en = push_i && (count != credit_w'(fifo_depth));
    assign rd_en = pop_i && not_empty_o;

    // head word shown without a register stage
    assign not_empty_o = (count != '0);
    assign word_o      = mem[rd_ptr];

    always_ff @(posedge clk_pixel) begin
        if (wr_en) begin
            mem[wr_ptr] <= word_i;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            // one credit goes back for each word taken
            credit_o <= rd_en;
            // pointers wrap naturally at a power-of-two depth
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // occupancy, simultaneous push and pop leave it unchanged
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- pixel_ingest.sv
module pixel_ingest
    import color_track_pkg::*;
(
    input  logic                   clk_pixel,
    input  logic                   sys_rst_pixel,
    input  logic                   pix_valid_i,
    input  rgb565_u                pix_data_i,
    output logic                   push_o,
    output logic [fifo_word_w-1:0] word_o
);

    // raster position of the pixel arriving next
    logic [x_w-1:0] x_cnt;
    logic [y_w-1:0] y_cnt;
    logic           x_at_end;
    logic           y_at_end;

    assign x_at_end = (x_cnt == x_w'(frame_w - 1));
    assign y_at_end = (y_cnt == y_w'(frame_h - 1));

    // control side: push strobe and position counters
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            push_o <= 1'b0;
            x_cnt  <= '0;
            y_cnt  <= '0;
        end else begin
            // sender only sends with a credit, so every pixel is pushed
            push_o <= pix_valid_i;
            if (pix_valid_i) begin
                if (x_at_end) begin
                    x_cnt <= '0;
                    // end of line moves down one row, bottom row wraps
                    if (y_at_end) begin
                        y_cnt <= '0;
                    end else begin
                        y_cnt <= y_cnt + 1'b1;
                    end
                end else begin
                    x_cnt <= x_cnt + 1'b1;
                end
            end
        end
    end

    // payload side: tag the pixel with where it sits in the frame
    always_ff @(posedge clk_pixel) begin
        if (pix_valid_i) begin
            // producer keeps the pixel as a raw word
            word_o[word_pix_lsb +: $bits(rgb565_u)] <= pix_data_i.raw;
            word_o[word_x_lsb +: x_w]               <= x_cnt;
            word_o[word_y_lsb +: y_w]               <= y_cnt;
            // bottom-right pixel closes the frame
            word_o[word_last_bit]                   <= x_at_end && y_at_end;
        end
    end

endmodule

//--- sources.f
+incdir+.
color_track_pkg.sv
pixel_ingest.sv
pixel_fifo.sv
mask_pipeline.sv
centroid_accum.sv
color_tracker_top.sv
tb_color_tracker.sv

//--- tb_color_tracker_ref.svh
// reference model of the colour path, included into the testbench module

// fibonacci lfsr, taps 32 22 2 1, shifts the new bit in at the bottom
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// saturate to one unsigned byte
function automatic int clip_byte(input int v);
    if (v < 0) begin
        return 0;
    end
    if (v > 255) begin
        return 255;
    end
    return v;
endfunction

// expected channel value of a raw rgb565 word for a select code
function automatic logic [chan_w-1:0] expected_chan(input logic [15:0] pix,
                                                    input logic [2:0] sel);
    int r;
    int g;
    int b;
    int yv;
    int cb;
    int cr;
    // fields moved to the top of a byte, low bits zero
    r  = int'({pix[15:11], 3'b000});
    g  = int'({pix[10:5], 2'b00});
    b  = int'({pix[4:0], 3'b000});
    // arithmetic shift on int gives floor for negative sums
    yv = clip_byte(16 + ((66 * r + 129 * g + 25 * b + 128) >>> 8));
    cb = clip_byte(128 + ((-38 * r - 74 * g + 112 * b + 128) >>> 8));
    cr = clip_byte(128 + ((112 * r - 94 * g - 18 * b + 128) >>> 8));
    case (sel)
        sel_green: return chan_w'(g);
        sel_red:   return chan_w'(r);
        sel_blue:  return chan_w'(b);
        sel_y:     return chan_w'(yv);
        sel_cr:    return chan_w'(cr);
        sel_cb:    return chan_w'(cb);
        // unused codes read as zero
        default:   return '0;
    endcase
endfunction

// inclusive window test
function automatic logic in_bounds(input logic [chan_w-1:0] v,
                                   input logic [chan_w-1:0] lo,
                                   input logic [chan_w-1:0] hi);
    return (v >= lo) && (v <= hi);
endfunction

// centre of mass along one axis, both operands non-negative so division floors
function automatic int floor_mean(input longint sum, input longint n);
    return int'(sum / n);
endfunction

//--- tb_color_tracker.sv
module tb_color_tracker
    import color_track_pkg::*;
();

    localparam int credit_timeout = 1000;
    localparam int drain_timeout  = 5000;
    localparam int com_timeout    = 2000;
    localparam int quiet_cycles   = 300;

    logic              clk_pixel;
    logic              sys_rst_pixel;
    logic              pix_valid_i;
    rgb565_u           pix_data_i;
    logic              credit_o;
    logic [2:0]        chan_sel_i;
    logic [chan_w-1:0] lower_i;
    logic [chan_w-1:0] upper_i;
    logic              mask_ready_i;
    logic              mask_valid_o;
    logic              mask_o;
    logic [chan_w-1:0] chan_o;
    logic              com_valid_o;
    logic [x_w-1:0]    com_x_o;
    logic [y_w-1:0]    com_y_o;

    // random source, sender credits and raster position of the next pixel
    logic [31:0] lfsr_state = 32'h167d66f8;
    int          credits;
    int          tx;
    int          ty;

    // expected output stream with the oldest beat at the front
    logic [chan_w-1:0] exp_chan_q[$];
    logic              exp_mask_q[$];
    int                exp_x_q[$];
    int                exp_y_q[$];
    logic              exp_last_q[$];
    // one expected centre per frame with hits
    int                com_x_exp_q[$];
    int                com_y_exp_q[$];

    // comparator state
    logic              held = 1'b0;
    logic [chan_w-1:0] held_chan;
    logic              held_mask;
    logic [chan_w-1:0] e_chan;
    logic              e_mask;
    int                e_x;
    int                e_y;
    logic              e_last;
    longint            sum_x = 0;
    longint            sum_y = 0;
    longint            hits = 0;
    int                cx;
    int                cy;

    `include "tb_color_tracker_ref.svh"

    color_tracker_top uut (
        .clk_pixel     (clk_pixel),
        .sys_rst_pixel (sys_rst_pixel),
        .pix_valid_i   (pix_valid_i),
        .pix_data_i    (pix_data_i),
        .credit_o      (credit_o),
        .chan_sel_i    (chan_sel_i),
        .lower_i       (lower_i),
        .upper_i       (upper_i),
        .mask_ready_i  (mask_ready_i),
        .mask_valid_o  (mask_valid_o),
        .mask_o        (mask_o),
        .chan_o        (chan_o),
        .com_valid_o   (com_valid_o),
        .com_x_o       (com_x_o),
        .com_y_o       (com_y_o)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #10 clk_pixel = ~clk_pixel;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    // n lfsr steps with one output bit per step
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // all input driving happens here
    // ready is high three cycles in four
    task automatic next_negedge();
        logic [31:0] bits;
        @(negedge clk_pixel);
        pix_valid_i = 1'b0;
        take_bits(2, bits);
        mask_ready_i = |bits[1:0];
    endtask

    task automatic record_expected(input logic [15:0] pix);
        logic [chan_w-1:0] v;
        v = expected_chan(pix, chan_sel_i);
        exp_chan_q.push_back(v);
        exp_mask_q.push_back(in_bounds(v, lower_i, upper_i));
        exp_x_q.push_back(tx);
        exp_y_q.push_back(ty);
        exp_last_q.push_back((tx == frame_w - 1) && (ty == frame_h - 1));
        // raster walk of the sender side
        if (tx == frame_w - 1) begin
            tx = 0;
            ty = (ty == frame_h - 1) ? 0 : ty + 1;
        end else begin
            tx = tx + 1;
        end
    endtask

    // one pixel is sent only while a credit is held and a random bit allows
    task automatic send_one(input logic [15:0] pix);
        logic [31:0] bits;
        int          waited;
        logic        sent;
        waited = 0;
        sent   = 1'b0;
        while (!sent) begin
            next_negedge();
            if (credits > 0) begin
                take_bits(1, bits);
                if (bits[0]) begin
                    pix_valid_i    = 1'b1;
                    pix_data_i.raw = pix;
                    credits        = credits - 1;
                    record_expected(pix);
                    sent = 1'b1;
                end
            end
            waited++;
            if (!sent && waited > credit_timeout) begin
                stop_on_error("timeout while waiting for a credit on credit_o");
            end
        end
    endtask

    // region mode puts full red inside a box and weak red elsewhere
    task automatic send_pixels(input int n, input logic region);
        logic [31:0] bits;
        logic [15:0] pix;
        for (int k = 0; k < n; k++) begin
            take_bits(16, bits);
            pix = bits[15:0];
            if (region) begin
                if (tx >= 100 && tx <= 149 && ty >= 60 && ty <= 89) begin
                    pix[15:11] = 5'd31;
                end else begin
                    pix[15] = 1'b0;
                end
            end
            send_one(pix);
        end
    endtask

    // drained means every credit is back and every pixel came out
    task automatic wait_drained();
        int waited;
        waited = 0;
        while (!(credits == fifo_depth && exp_chan_q.size() == 0)) begin
            next_negedge();
            waited++;
            if (waited > drain_timeout) begin
                stop_on_error("timeout while waiting for the stream to drain");
            end
        end
    endtask

    // credits come back on credit_o and are counted at the rising edge
    always @(posedge clk_pixel) begin
        if (!sys_rst_pixel && credit_o === 1'b1) begin
            credits = credits + 1;
            assert (credits <= fifo_depth)
            else stop_on_error("credit_o returned more credits than pixels were sent");
        end
    end

    // output stream checker
    always @(posedge clk_pixel) begin
        if (!sys_rst_pixel) begin
            // a stalled beat must still be there and unchanged
            if (held) begin
                assert (mask_valid_o === 1'b1)
                else stop_on_error("mask_valid_o dropped while the output was stalled");
                assert (chan_o == held_chan)
                else stop_on_error($sformatf("error at %0t: chan_o is %0h while stalled, held %0h",
                                             $time, chan_o, held_chan));
                assert (mask_o == held_mask)
                else stop_on_error($sformatf("error at %0t: mask_o is %0b while stalled, held %0b",
                                             $time, mask_o, held_mask));
            end
            held      = (mask_valid_o === 1'b1) && !mask_ready_i;
            held_chan = chan_o;
            held_mask = mask_o;
            if (mask_valid_o === 1'b1 && mask_ready_i) begin
                assert (exp_chan_q.size() > 0)
                else stop_on_error("output handshake with no pixel outstanding");
                e_chan = exp_chan_q.pop_front();
                e_mask = exp_mask_q.pop_front();
                e_x    = exp_x_q.pop_front();
                e_y    = exp_y_q.pop_front();
                e_last = exp_last_q.pop_front();
                assert (chan_o == e_chan)
                else stop_on_error($sformatf("error at %0t: chan_o is %0h, expected %0h",
                                             $time, chan_o, e_chan));
                assert (mask_o == e_mask)
                else stop_on_error($sformatf("error at %0t: mask_o is %0b, expected %0b",
                                             $time, mask_o, e_mask));
                if (e_mask) begin
                    sum_x = sum_x + e_x;
                    sum_y = sum_y + e_y;
                    hits  = hits + 1;
                end
                // at the end of a frame a centre is due only when something was masked
                if (e_last) begin
                    if (hits > 0) begin
                        com_x_exp_q.push_back(floor_mean(sum_x, hits));
                        com_y_exp_q.push_back(floor_mean(sum_y, hits));
                    end
                    sum_x = 0;
                    sum_y = 0;
                    hits  = 0;
                end
            end
        end
    end

    // centre of mass checker
    always @(posedge clk_pixel) begin
        if (!sys_rst_pixel && com_valid_o === 1'b1) begin
            assert (com_x_exp_q.size() > 0)
            else stop_on_error("com_valid_o pulsed with no centre of mass outstanding");
            cx = com_x_exp_q.pop_front();
            cy = com_y_exp_q.pop_front();
            assert (com_x_o == x_w'(cx))
            else stop_on_error($sformatf("error at %0t: com_x_o is %0d, expected %0d",
                                         $time, com_x_o, cx));
            assert (com_y_o == y_w'(cy))
            else stop_on_error($sformatf("error at %0t: com_y_o is %0d, expected %0d",
                                         $time, com_y_o, cy));
        end
    end

    initial begin
        logic [31:0] bits;
        int          waited;
        sys_rst_pixel  = 1'b1;
        pix_valid_i    = 1'b0;
        pix_data_i.raw = '0;
        chan_sel_i     = sel_green;
        lower_i        = '0;
        upper_i        = '0;
        mask_ready_i   = 1'b0;
        credits        = fifo_depth;
        tx             = 0;
        ty             = 0;
        repeat (4) @(negedge clk_pixel);
        sys_rst_pixel = 1'b0;

        // outputs stay idle after reset while nothing is sent
        for (int k = 0; k < 6; k++) begin
            next_negedge();
            assert (credit_o === 1'b0 && mask_valid_o === 1'b0 && com_valid_o === 1'b0)
            else stop_on_error("an output strobe is not low after reset");
        end

        // frame 1 cycles through all eight codes with random bounds
        for (int seg = 0; seg < frame_w * frame_h / 256; seg++) begin
            take_bits(16, bits);
            chan_sel_i = 3'(seg % 8);
            if (bits[15:8] <= bits[7:0]) begin
                lower_i = bits[15:8];
                upper_i = bits[7:0];
            end else begin
                lower_i = bits[7:0];
                upper_i = bits[15:8];
            end
            send_pixels(256, 1'b0);
            wait_drained();
        end

        // frame 2 masks a red box at x 100..149, y 60..89
        chan_sel_i = sel_red;
        lower_i    = 8'd200;
        upper_i    = 8'd255;
        send_pixels(frame_w * frame_h, 1'b1);
        wait_drained();

        // frame 3 selects an unused code whose zero never passes a lower bound of 1
        chan_sel_i = 3'd3;
        lower_i    = 8'd1;
        upper_i    = 8'd255;
        send_pixels(frame_w * frame_h, 1'b0);
        wait_drained();

        waited = 0;
        while (com_x_exp_q.size() != 0) begin
            next_negedge();
            waited++;
            if (waited > com_timeout) begin
                stop_on_error("timeout while waiting for com_valid_o");
            end
        end
        // the empty frame must stay silent
        for (int k = 0; k < quiet_cycles; k++) begin
            next_negedge();
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
